// File: source/bus_types_pkg.sv
// bus side types
package bus_types_pkg;

    // one bus data word
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // master to slave
    typedef struct packed {
        addr_t addr;
        logic  select;
        logic  enable;
        logic  write;
        word_t wdata;
    } bus_req_t;

    // slave to master
    typedef struct packed {
        word_t rdata;
        logic  ready;
    } bus_rsp_t;

endpackage

// File: source/client_pkg.sv
// client request and grant types
package client_pkg;

    // line sizes in bytes
    localparam int DCACHE_LINE_SIZE = 16;
    localparam int ICACHE_LINE_SIZE = 32;

    localparam int WORD_BYTES = $bits(bus_types_pkg::word_t) / 8;
    localparam int DCACHE_WORD_COUNT = DCACHE_LINE_SIZE / WORD_BYTES;
    localparam int ICACHE_WORD_COUNT = ICACHE_LINE_SIZE / WORD_BYTES;

    typedef bus_types_pkg::word_t [DCACHE_WORD_COUNT-1:0] dcache_line_t;
    typedef bus_types_pkg::word_t [ICACHE_WORD_COUNT-1:0] icache_line_t;

    // single word clients
    typedef struct packed {
        logic                 read_req;
        logic                 write_req;
        bus_types_pkg::addr_t addr;
        bus_types_pkg::word_t write_value;
    } tlb_req_t;

    typedef struct packed {
        logic                 read_grant;
        logic                 write_grant;
        bus_types_pkg::word_t read_value;
    } tlb_grant_t;

    // line clients
    typedef struct packed {
        logic                 read_req;
        logic                 write_req;
        bus_types_pkg::addr_t addr;
        dcache_line_t         write_value;
    } dcache_req_t;

    typedef struct packed {
        logic         read_grant;
        logic         write_grant;
        dcache_line_t read_value;
    } dcache_grant_t;

    typedef struct packed {
        logic                 read_req;
        logic                 write_req;
        bus_types_pkg::addr_t addr;
        icache_line_t         write_value;
    } icache_req_t;

    typedef struct packed {
        logic         read_grant;
        logic         write_grant;
        icache_line_t read_value;
    } icache_grant_t;

endpackage

// File: source/bus_memory.sv
// bus slave memory
`timescale 1ns/1ps

module bus_memory #(
    parameter int unsigned MEM_WORDS   = 1024,
    parameter int unsigned WAIT_CYCLES = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_types_pkg::bus_req_t bus_req,
    output bus_types_pkg::bus_rsp_t bus_rsp
);
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    bus_types_pkg::word_t mem [MEM_WORDS];

    logic [CNT_W-1:0] wait_count;
    logic [IDX_W-1:0] index;
    logic access;
    logic ready;

    // word address wraps at the memory depth
    assign index = IDX_W'({2'b00, bus_req.addr[31:2]} % MEM_WORDS);

    assign access = bus_req.select && bus_req.enable;
    assign ready = access && (wait_count == CNT_W'(WAIT_CYCLES));

    // counts access cycles of the current transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_count <= '0;
        end else if (access && !ready) begin
            wait_count <= wait_count + 1'b1;
        end else begin
            wait_count <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && bus_req.write) begin
            mem[index] <= bus_req.wdata;
        end
    end

    // read data straight from the array
    assign bus_rsp.rdata = mem[index];
    assign bus_rsp.ready = ready;

    a_write_enable: assert property (@(posedge clk) disable iff (rst)
        bus_req.write |-> bus_req.enable);

endmodule

// File: source/bus_access_unit.sv
// bus access unit
`timescale 1ns/1ps

module bus_access_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  client_pkg::tlb_req_t      dtlb_req,
    input  client_pkg::tlb_req_t      itlb_req,
    input  client_pkg::dcache_req_t   dcache_req,
    input  client_pkg::icache_req_t   icache_req,
    output client_pkg::tlb_grant_t    dtlb_grant,
    output client_pkg::tlb_grant_t    itlb_grant,
    output client_pkg::dcache_grant_t dcache_grant,
    output client_pkg::icache_grant_t icache_grant,
    output bus_types_pkg::bus_req_t   bus_req,
    input  bus_types_pkg::bus_rsp_t   bus_rsp
);
    localparam int DCACHE_OFFSET = $clog2(client_pkg::DCACHE_LINE_SIZE);
    localparam int ICACHE_OFFSET = $clog2(client_pkg::ICACHE_LINE_SIZE);

    typedef logic [$clog2(client_pkg::DCACHE_WORD_COUNT)-1:0] dcache_index_t;
    typedef logic [$clog2(client_pkg::ICACHE_WORD_COUNT)-1:0] icache_index_t;

    localparam dcache_index_t DCACHE_LAST = dcache_index_t'(client_pkg::DCACHE_WORD_COUNT - 1);
    localparam icache_index_t ICACHE_LAST = icache_index_t'(client_pkg::ICACHE_WORD_COUNT - 1);

    typedef enum logic [3:0] {
        ST_IDLE         = 4'h0,
        ST_DCACHE_READ  = 4'h8,
        ST_DCACHE_WRITE = 4'h9,
        ST_DTLB_READ    = 4'ha,
        ST_DTLB_WRITE   = 4'hb,
        ST_ICACHE_READ  = 4'hc,
        ST_ICACHE_WRITE = 4'hd,
        ST_ITLB_READ    = 4'he,
        ST_ITLB_WRITE   = 4'hf
    } xfer_state_t;

    typedef enum logic [1:0] {
        PHASE_IDLE   = 2'h0,
        PHASE_SETUP  = 2'h1,
        PHASE_ACCESS = 2'h2
    } phase_t;

    xfer_state_t state;
    xfer_state_t next_state;
    phase_t phase;
    phase_t next_phase;
    logic done;
    logic next_done;
    logic rdata_valid;
    dcache_index_t dcache_index;
    icache_index_t icache_index;
    client_pkg::dcache_line_t dcache_value;
    client_pkg::icache_line_t icache_value;
    bus_types_pkg::word_t tlb_value;

    assign rdata_valid = (phase == PHASE_ACCESS) && bus_rsp.ready;

    // fixed priority pick while idle
    always_comb begin
        if (state != ST_IDLE) begin
            next_state = done ? ST_IDLE : state;
        end else if (dtlb_req.write_req) begin
            next_state = ST_DTLB_WRITE;
        end else if (dtlb_req.read_req) begin
            next_state = ST_DTLB_READ;
        end else if (dcache_req.write_req) begin
            next_state = ST_DCACHE_WRITE;
        end else if (dcache_req.read_req) begin
            next_state = ST_DCACHE_READ;
        end else if (itlb_req.write_req) begin
            next_state = ST_ITLB_WRITE;
        end else if (itlb_req.read_req) begin
            next_state = ST_ITLB_READ;
        end else if (icache_req.write_req) begin
            next_state = ST_ICACHE_WRITE;
        end else if (icache_req.read_req) begin
            next_state = ST_ICACHE_READ;
        end else begin
            next_state = ST_IDLE;
        end
    end

    // one apb transfer per word
    always_comb begin
        if (state == ST_IDLE || done) begin
            next_phase = PHASE_IDLE;
        end else begin
            case (phase)
                PHASE_IDLE:   next_phase = PHASE_SETUP;
                PHASE_SETUP:  next_phase = PHASE_ACCESS;
                PHASE_ACCESS: next_phase = bus_rsp.ready ? PHASE_IDLE : PHASE_ACCESS;
                default:      next_phase = PHASE_IDLE;
            endcase
        end
    end

    // last word of the transfer
    always_comb begin
        if (state inside {ST_DCACHE_READ, ST_DCACHE_WRITE}) begin
            next_done = rdata_valid && (dcache_index == DCACHE_LAST);
        end else if (state inside {ST_ICACHE_READ, ST_ICACHE_WRITE}) begin
            next_done = rdata_valid && (icache_index == ICACHE_LAST);
        end else if (state != ST_IDLE) begin
            next_done = rdata_valid;
        end else begin
            next_done = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            phase <= PHASE_IDLE;
            done <= 1'b0;
            dcache_index <= '0;
            icache_index <= '0;
        end else begin
            state <= next_state;
            phase <= next_phase;
            done <= next_done;
            if (state == ST_IDLE) begin
                dcache_index <= '0;
                icache_index <= '0;
            end else if (rdata_valid) begin
                if (state inside {ST_DCACHE_READ, ST_DCACHE_WRITE}) begin
                    dcache_index <= dcache_index + 1'b1;
                end
                if (state inside {ST_ICACHE_READ, ST_ICACHE_WRITE}) begin
                    icache_index <= icache_index + 1'b1;
                end
            end
        end
    end

    // write values latched at the sampling edge, read data collected per word
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            dcache_value <= dcache_req.write_value;
            icache_value <= icache_req.write_value;
            tlb_value <= dtlb_req.write_req ? dtlb_req.write_value : itlb_req.write_value;
        end else if (rdata_valid) begin
            if (state == ST_DCACHE_READ) begin
                dcache_value[dcache_index] <= bus_rsp.rdata;
            end
            if (state == ST_ICACHE_READ) begin
                icache_value[icache_index] <= bus_rsp.rdata;
            end
            if (state inside {ST_DTLB_READ, ST_ITLB_READ}) begin
                tlb_value <= bus_rsp.rdata;
            end
        end
    end

    // bus master outputs
    always_comb begin
        if (state inside {ST_DTLB_READ, ST_DTLB_WRITE}) begin
            bus_req.addr = {dtlb_req.addr[31:2], 2'b00};
            bus_req.wdata = tlb_value;
        end else if (state inside {ST_ITLB_READ, ST_ITLB_WRITE}) begin
            bus_req.addr = {itlb_req.addr[31:2], 2'b00};
            bus_req.wdata = tlb_value;
        end else if (state inside {ST_DCACHE_READ, ST_DCACHE_WRITE}) begin
            bus_req.addr = {dcache_req.addr[31:DCACHE_OFFSET], dcache_index, 2'b00};
            bus_req.wdata = dcache_value[dcache_index];
        end else if (state inside {ST_ICACHE_READ, ST_ICACHE_WRITE}) begin
            bus_req.addr = {icache_req.addr[31:ICACHE_OFFSET], icache_index, 2'b00};
            bus_req.wdata = icache_value[icache_index];
        end else begin
            bus_req.addr = '0;
            bus_req.wdata = '0;
        end
        bus_req.select = (phase == PHASE_SETUP) || (phase == PHASE_ACCESS);
        bus_req.enable = (phase == PHASE_ACCESS);
        bus_req.write = (phase == PHASE_ACCESS) &&
            (state inside {ST_DTLB_WRITE, ST_DCACHE_WRITE, ST_ITLB_WRITE, ST_ICACHE_WRITE});
    end

    // grant pulses from the registered done flag
    always_comb begin
        dtlb_grant.read_grant = done && (state == ST_DTLB_READ);
        dtlb_grant.write_grant = done && (state == ST_DTLB_WRITE);
        dtlb_grant.read_value = tlb_value;
        itlb_grant.read_grant = done && (state == ST_ITLB_READ);
        itlb_grant.write_grant = done && (state == ST_ITLB_WRITE);
        itlb_grant.read_value = tlb_value;
        dcache_grant.read_grant = done && (state == ST_DCACHE_READ);
        dcache_grant.write_grant = done && (state == ST_DCACHE_WRITE);
        dcache_grant.read_value = dcache_value;
        icache_grant.read_grant = done && (state == ST_ICACHE_READ);
        icache_grant.write_grant = done && (state == ST_ICACHE_WRITE);
        icache_grant.read_value = icache_value;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dtlb_grant.read_grant, dtlb_grant.write_grant,
                  itlb_grant.read_grant, itlb_grant.write_grant,
                  dcache_grant.read_grant, dcache_grant.write_grant,
                  icache_grant.read_grant, icache_grant.write_grant}));

    a_enable_select: assert property (@(posedge clk) disable iff (rst)
        bus_req.enable |-> bus_req.select);

    // slave stretch must keep the transfer open
    a_hold_access: assert property (@(posedge clk) disable iff (rst)
        (bus_req.select && bus_req.enable && !bus_rsp.ready)
            |=> (bus_req.select && bus_req.enable));

endmodule

// File: source/bus_access_top.sv
// bus access top level
`timescale 1ns/1ps

module bus_access_top #(
    parameter int unsigned MEM_WORDS   = 1024,
    parameter int unsigned WAIT_CYCLES = 1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  client_pkg::tlb_req_t      dtlb_req,
    input  client_pkg::tlb_req_t      itlb_req,
    input  client_pkg::dcache_req_t   dcache_req,
    input  client_pkg::icache_req_t   icache_req,
    output client_pkg::tlb_grant_t    dtlb_grant,
    output client_pkg::tlb_grant_t    itlb_grant,
    output client_pkg::dcache_grant_t dcache_grant,
    output client_pkg::icache_grant_t icache_grant
);
    bus_types_pkg::bus_req_t bus_req;
    bus_types_pkg::bus_rsp_t bus_rsp;

    bus_access_unit unit_i (
        .clk          (clk),
        .rst          (rst),
        .dtlb_req     (dtlb_req),
        .itlb_req     (itlb_req),
        .dcache_req   (dcache_req),
        .icache_req   (icache_req),
        .dtlb_grant   (dtlb_grant),
        .itlb_grant   (itlb_grant),
        .dcache_grant (dcache_grant),
        .icache_grant (icache_grant),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp)
    );

    // shared by all four clients
    bus_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) memory_i (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

// File: testbench/bus_access_tb_ref.svh
// bus access reference model
`ifndef BUS_ACCESS_TB_REF_SVH
`define BUS_ACCESS_TB_REF_SVH

// shadow of the bus memory, keyed by word index
bus_types_pkg::word_t shadow [int unsigned];

function automatic int unsigned shadow_index(input bus_types_pkg::addr_t addr);
    return (addr >> 2) % dut_i.MEM_WORDS;
endfunction

function automatic int unsigned word_count(input int client);
    case (client)
        CL_DCACHE: return client_pkg::DCACHE_WORD_COUNT;
        CL_ICACHE: return client_pkg::ICACHE_WORD_COUNT;
        default:   return 1;
    endcase
endfunction

// lines are aligned from the upper address bits
function automatic bus_types_pkg::addr_t align_address(input int client,
                                                       input bus_types_pkg::addr_t addr);
    return addr & ~bus_types_pkg::addr_t'(word_count(client) * 4 - 1);
endfunction

function automatic void store_words(input int client, input bus_types_pkg::addr_t addr,
                                    input client_pkg::icache_line_t data);
    bus_types_pkg::addr_t base;
    base = align_address(client, addr);
    for (int unsigned i = 0; i < word_count(client); i++) begin
        shadow[shadow_index(base + 4 * i)] = data[i];
    end
endfunction

function automatic bit words_written(input int client, input bus_types_pkg::addr_t addr);
    bus_types_pkg::addr_t base;
    base = align_address(client, addr);
    for (int unsigned i = 0; i < word_count(client); i++) begin
        if (!shadow.exists(shadow_index(base + 4 * i))) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

function automatic bus_types_pkg::word_t expected_tlb_word(input bus_types_pkg::addr_t addr);
    return shadow[shadow_index(align_address(CL_DTLB, addr))];
endfunction

function automatic client_pkg::dcache_line_t expected_dcache_line(
    input bus_types_pkg::addr_t addr
);
    client_pkg::dcache_line_t line;
    bus_types_pkg::addr_t base;
    base = align_address(CL_DCACHE, addr);
    for (int unsigned i = 0; i < client_pkg::DCACHE_WORD_COUNT; i++) begin
        line[i] = shadow[shadow_index(base + 4 * i)];
    end
    return line;
endfunction

function automatic client_pkg::icache_line_t expected_icache_line(
    input bus_types_pkg::addr_t addr
);
    client_pkg::icache_line_t line;
    bus_types_pkg::addr_t base;
    base = align_address(CL_ICACHE, addr);
    for (int unsigned i = 0; i < client_pkg::ICACHE_WORD_COUNT; i++) begin
        line[i] = shadow[shadow_index(base + 4 * i)];
    end
    return line;
endfunction

// idle, setup and W+1 access cycles per word
function automatic int unsigned expected_grant_edges(input int unsigned words);
    return words * (3 + dut_i.WAIT_CYCLES);
endfunction

`endif

// File: testbench/bus_access_tb.sv
// bus access testbench
`timescale 1ns/1ps

module bus_access_tb;
    localparam int CL_DTLB = 0;
    localparam int CL_DCACHE = 1;
    localparam int CL_ITLB = 2;
    localparam int CL_ICACHE = 3;
    localparam int unsigned TIMEOUT = 1000;

    typedef struct packed {
        logic [1:0]               client;
        logic                     write;
        logic [31:0]              issue_edge;
        client_pkg::icache_line_t expected;
    } expect_t;

    logic clk;
    logic rst;
    client_pkg::tlb_req_t      dtlb_req;
    client_pkg::tlb_req_t      itlb_req;
    client_pkg::dcache_req_t   dcache_req;
    client_pkg::icache_req_t   icache_req;
    client_pkg::tlb_grant_t    dtlb_grant;
    client_pkg::tlb_grant_t    itlb_grant;
    client_pkg::dcache_grant_t dcache_grant;
    client_pkg::icache_grant_t icache_grant;

    expect_t pending [$];
    int unsigned edge_count = 0;
    int unsigned last_grant_edge = 0;
    int unsigned issued = 0;
    int unsigned completed = 0;

    `include "bus_access_tb_ref.svh"

    bus_access_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .dtlb_req     (dtlb_req),
        .itlb_req     (itlb_req),
        .dcache_req   (dcache_req),
        .icache_req   (icache_req),
        .dtlb_grant   (dtlb_grant),
        .itlb_grant   (itlb_grant),
        .dcache_grant (dcache_grant),
        .icache_grant (icache_grant)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_tlb_word(input string name, input bus_types_pkg::word_t actual,
                                  input bus_types_pkg::word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_dcache_line(input string name, input client_pkg::dcache_line_t actual,
                                     input client_pkg::dcache_line_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_icache_line(input string name, input client_pkg::icache_line_t actual,
                                     input client_pkg::icache_line_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_latency(input string name, input int unsigned actual,
                                 input int unsigned expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED: %s got %0h expected %0h", name, actual, expected));
        end
    endtask

    // two bits per client in priority order, read below write
    function automatic logic [7:0] grant_vector();
        return {icache_grant.write_grant, icache_grant.read_grant,
                itlb_grant.write_grant, itlb_grant.read_grant,
                dcache_grant.write_grant, dcache_grant.read_grant,
                dtlb_grant.write_grant, dtlb_grant.read_grant};
    endfunction

    function automatic client_pkg::icache_line_t pattern_line(input bus_types_pkg::addr_t base,
                                                              input bus_types_pkg::word_t tag);
        client_pkg::icache_line_t line;
        for (int unsigned i = 0; i < client_pkg::ICACHE_WORD_COUNT; i++) begin
            line[i] = tag ^ (base + 4 * i);
        end
        return line;
    endfunction

    function automatic client_pkg::icache_line_t random_line();
        client_pkg::icache_line_t line;
        for (int unsigned i = 0; i < client_pkg::ICACHE_WORD_COUNT; i++) begin
            line[i] = $urandom;
        end
        return line;
    endfunction

    task automatic release_client(input int client);
        case (client)
            CL_DTLB:   dtlb_req = '0;
            CL_DCACHE: dcache_req = '0;
            CL_ITLB:   itlb_req = '0;
            default:   icache_req = '0;
        endcase
    endtask

    task automatic issue_request(input int client, input logic write,
                                 input bus_types_pkg::addr_t addr,
                                 input client_pkg::icache_line_t data);
        expect_t entry;
        entry = '0;
        entry.client = 2'(client);
        entry.write = write;
        entry.issue_edge = edge_count;
        if (write) begin
            store_words(client, addr, data);
        end else if (client == CL_DTLB || client == CL_ITLB) begin
            entry.expected[0] = expected_tlb_word(addr);
        end else if (client == CL_DCACHE) begin
            entry.expected[client_pkg::DCACHE_WORD_COUNT-1:0] = expected_dcache_line(addr);
        end else begin
            entry.expected = expected_icache_line(addr);
        end
        case (client)
            CL_DTLB: dtlb_req = '{read_req: !write, write_req: write, addr: addr,
                                  write_value: data[0]};
            CL_ITLB: itlb_req = '{read_req: !write, write_req: write, addr: addr,
                                  write_value: data[0]};
            CL_DCACHE: dcache_req = '{read_req: !write, write_req: write, addr: addr,
                                      write_value: data[client_pkg::DCACHE_WORD_COUNT-1:0]};
            default: icache_req = '{read_req: !write, write_req: write, addr: addr,
                                    write_value: data};
        endcase
        pending.push_back(entry);
        issued = issued + 1;
    endtask

    // drops each request the cycle after its grant
    task automatic wait_all_done();
        logic [3:0] clear_mask;
        logic [7:0] grants;
        int unsigned cycles;
        clear_mask = '0;
        cycles = 0;
        while (completed != issued || clear_mask != 4'h0) begin
            @(posedge clk);
            #1;
            for (int c = 0; c < 4; c++) begin
                if (clear_mask[c]) begin
                    release_client(c);
                end
            end
            grants = grant_vector();
            for (int c = 0; c < 4; c++) begin
                clear_mask[c] = grants[2 * c] | grants[2 * c + 1];
            end
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                fail_run("timed out waiting for outstanding requests to be granted");
            end
        end
    endtask

    initial begin : compare_grants
        expect_t entry;
        logic [7:0] grants;
        logic [7:0] wanted;
        int unsigned waited;
        int unsigned sampling_edge;
        waited = 0;
        forever begin
            @(posedge clk);
            #1;
            grants = grant_vector();
            if (pending.size() == 0) begin
                if (grants !== 8'h00) begin
                    fail_run($sformatf("grant %h raised with no request outstanding", grants));
                end
            end else begin
                entry = pending[0];
                wanted = 8'h01 << (2 * int'(entry.client) + int'(entry.write));
                waited = waited + 1;
                if (grants === wanted) begin
                    // sampled one edge after issue, or two after the previous grant
                    sampling_edge = entry.issue_edge + 1;
                    if (last_grant_edge + 2 > sampling_edge) begin
                        sampling_edge = last_grant_edge + 2;
                    end
                    check_latency("grant latency", edge_count - sampling_edge,
                                  expected_grant_edges(word_count(int'(entry.client))));
                    if (!entry.write) begin
                        case (int'(entry.client))
                            CL_DTLB: check_tlb_word("dtlb_grant.read_value",
                                                    dtlb_grant.read_value, entry.expected[0]);
                            CL_ITLB: check_tlb_word("itlb_grant.read_value",
                                                    itlb_grant.read_value, entry.expected[0]);
                            CL_DCACHE: check_dcache_line("dcache_grant.read_value",
                                dcache_grant.read_value,
                                entry.expected[client_pkg::DCACHE_WORD_COUNT-1:0]);
                            default: check_icache_line("icache_grant.read_value",
                                                       icache_grant.read_value, entry.expected);
                        endcase
                    end
                    void'(pending.pop_front());
                    last_grant_edge = edge_count;
                    completed = completed + 1;
                    waited = 0;
                end else if (grants !== 8'h00) begin
                    fail_run($sformatf("grant %h arrived while grant %h was due", grants, wanted));
                end else if (waited > TIMEOUT) begin
                    fail_run("timed out waiting for a grant from the bus access unit");
                end
            end
        end
    end

    initial begin : stimulus
        int client;
        logic write;
        bus_types_pkg::addr_t addr;
        void'($urandom(32'hce95));
        rst = 1'b1;
        dtlb_req = '0;
        itlb_req = '0;
        dcache_req = '0;
        icache_req = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #1;

        // single words on both tlb ports
        issue_request(CL_DTLB, 1'b1, 32'h0000_0100, pattern_line(32'h0000_0100, 32'h5a00_0000));
        wait_all_done();
        issue_request(CL_DTLB, 1'b0, 32'h0000_0100, '0);
        wait_all_done();
        issue_request(CL_ITLB, 1'b1, 32'h0000_0204, pattern_line(32'h0000_0204, 32'h3c00_0000));
        wait_all_done();
        issue_request(CL_ITLB, 1'b0, 32'h0000_0204, '0);
        wait_all_done();

        // both caches see one memory
        issue_request(CL_DCACHE, 1'b1, 32'h0000_0400, pattern_line(32'h0000_0400, 32'h1100_0000));
        wait_all_done();
        issue_request(CL_DCACHE, 1'b1, 32'h0000_0410, pattern_line(32'h0000_0410, 32'h2200_0000));
        wait_all_done();
        issue_request(CL_ICACHE, 1'b0, 32'h0000_0400, '0);
        wait_all_done();
        issue_request(CL_ICACHE, 1'b1, 32'h0000_0480, pattern_line(32'h0000_0480, 32'h7700_0000));
        wait_all_done();
        issue_request(CL_DCACHE, 1'b0, 32'h0000_0490, '0);
        wait_all_done();
        issue_request(CL_DCACHE, 1'b0, 32'h0000_0480, '0);
        wait_all_done();

        // all four clients raised in one cycle
        issue_request(CL_DTLB, 1'b0, 32'h0000_0100, '0);
        issue_request(CL_DCACHE, 1'b1, 32'h0000_0600, pattern_line(32'h0000_0600, 32'h4400_0000));
        issue_request(CL_ITLB, 1'b1, 32'h0000_0700, pattern_line(32'h0000_0700, 32'h6600_0000));
        issue_request(CL_ICACHE, 1'b0, 32'h0000_0400, '0);
        wait_all_done();
        issue_request(CL_DTLB, 1'b1, 32'h0000_0140, pattern_line(32'h0000_0140, 32'h8800_0000));
        issue_request(CL_DCACHE, 1'b0, 32'h0000_0480, '0);
        issue_request(CL_ITLB, 1'b0, 32'h0000_0204, '0);
        issue_request(CL_ICACHE, 1'b1, 32'h0000_0800, pattern_line(32'h0000_0800, 32'h9900_0000));
        wait_all_done();

        // random traffic, reads only where the shadow is filled
        repeat (200) begin
            client = int'($urandom_range(3, 0));
            write = 1'($urandom_range(1, 0));
            addr = align_address(client, {22'h0, 8'($urandom_range(255, 0)), 2'b00});
            if (!write && !words_written(client, addr)) begin
                write = 1'b1;
            end
            issue_request(client, write, addr, random_line());
            wait_all_done();
        end

        repeat (8) @(posedge clk);
        #1;
        if (completed == 0) begin
            fail_run("no grant was checked during the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: bus_access.f
source/bus_types_pkg.sv
source/client_pkg.sv
source/bus_memory.sv
source/bus_access_unit.sv
source/bus_access_top.sv
+incdir+testbench
testbench/bus_access_tb.sv

// File: Makefile
# Verilator simulation of the bus access unit

VERILATOR ?= verilator
TOP       ?= bus_access_tb
FILELIST  ?= bus_access.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
